//--- common/fu_pkg.sv
package fu_pkg;

    typedef logic [31:0] word_t;    // operands, results, pc
    typedef logic [2:0]  gen_op_t;  // operation class
    typedef logic [4:0]  spec_op_t; // op code within its class
    typedef logic [25:0] imm_t;     // raw immediate, widest format is offs26
    typedef logic [2:0]  res_sel_t;

    // operation classes
    localparam gen_op_t OPTYPE_INVALID = 3'd0;
    localparam gen_op_t OPTYPE_3R      = 3'd1;
    localparam gen_op_t OPTYPE_2R12I   = 3'd2;
    localparam gen_op_t OPTYPE_2R5I    = 3'd3;
    localparam gen_op_t OPTYPE_1R20I   = 3'd4;
    localparam gen_op_t OPTYPE_BJ      = 3'd5;

    // 3R
    localparam spec_op_t OP_ADD   = 5'd0;
    localparam spec_op_t OP_SUB   = 5'd1;
    localparam spec_op_t OP_SLT   = 5'd2;
    localparam spec_op_t OP_SLTU  = 5'd3;
    localparam spec_op_t OP_NOR   = 5'd4;
    localparam spec_op_t OP_AND   = 5'd5;
    localparam spec_op_t OP_OR    = 5'd6;
    localparam spec_op_t OP_XOR   = 5'd7;
    localparam spec_op_t OP_SLL   = 5'd8;
    localparam spec_op_t OP_SRL   = 5'd9;
    localparam spec_op_t OP_SRA   = 5'd10;
    localparam spec_op_t OP_MUL   = 5'd11;
    localparam spec_op_t OP_MULH  = 5'd12;
    localparam spec_op_t OP_MULHU = 5'd13;

    // 2R12I, codes from 8 up belong to loads and stores
    localparam spec_op_t OP_SLTI  = 5'd0;
    localparam spec_op_t OP_SLTUI = 5'd1;
    localparam spec_op_t OP_ADDI  = 5'd2;
    localparam spec_op_t OP_ANDI  = 5'd3;
    localparam spec_op_t OP_ORI   = 5'd4;
    localparam spec_op_t OP_XORI  = 5'd5;

    // 2R5I
    localparam spec_op_t OP_SLLI = 5'd0;
    localparam spec_op_t OP_SRLI = 5'd1;
    localparam spec_op_t OP_SRAI = 5'd2;

    // 1R20I
    localparam spec_op_t OP_LU12I     = 5'd0;
    localparam spec_op_t OP_PCADDU12I = 5'd1;

    // branch and jump
    localparam spec_op_t OP_BEQ  = 5'd0;
    localparam spec_op_t OP_BNE  = 5'd1;
    localparam spec_op_t OP_BLT  = 5'd2;
    localparam spec_op_t OP_BGE  = 5'd3;
    localparam spec_op_t OP_BLTU = 5'd4;
    localparam spec_op_t OP_BGEU = 5'd5;
    localparam spec_op_t OP_JIRL = 5'd6;
    localparam spec_op_t OP_B    = 5'd7;
    localparam spec_op_t OP_BL   = 5'd8;

    // result select
    localparam res_sel_t SEL_ADDSUB = 3'd0;
    localparam res_sel_t SEL_SHIFT  = 3'd1;
    localparam res_sel_t SEL_CMP    = 3'd2;
    localparam res_sel_t SEL_LOGIC  = 3'd3;
    localparam res_sel_t SEL_MUL_LO = 3'd4;
    localparam res_sel_t SEL_MUL_HI = 3'd5;
    localparam res_sel_t SEL_BJ     = 3'd6;

    typedef struct packed {
        gen_op_t  gen_op;
        spec_op_t spec_op;
        imm_t     imm;
        word_t    pc;
        logic     pred_taken;
        word_t    pred_target; // from the branch predictor
    } issue_info_t;

    typedef struct packed {
        logic  taken;
        word_t target;
        logic  pred_wrong;
    } bj_out_t;

endpackage

//--- verilog/op_decode.sv
`timescale 1ns/1ns

module op_decode (
    input  fu_pkg::issue_info_t issue,
    output fu_pkg::res_sel_t    res_sel,
    output logic                add_mode,      // high is add, low is sub
    output logic                mul_signed_hi,
    output logic                op_ok
);
    import fu_pkg::*;

    always_comb begin
        res_sel       = SEL_ADDSUB;
        add_mode      = 1'b1;
        mul_signed_hi = 1'b1; // only mulhu needs zero extension
        op_ok         = 1'b1;
        case (issue.gen_op)
            OPTYPE_3R: begin
                case (issue.spec_op)
                    OP_ADD:                        res_sel = SEL_ADDSUB;
                    OP_SUB:                        add_mode = 1'b0;
                    OP_SLT, OP_SLTU:               res_sel = SEL_CMP;
                    OP_NOR, OP_AND, OP_OR, OP_XOR: res_sel = SEL_LOGIC;
                    OP_SLL, OP_SRL, OP_SRA:        res_sel = SEL_SHIFT;
                    OP_MUL:                        res_sel = SEL_MUL_LO;
                    OP_MULH:                       res_sel = SEL_MUL_HI;
                    OP_MULHU: begin
                        res_sel       = SEL_MUL_HI;
                        mul_signed_hi = 1'b0;
                    end
                    default:                       op_ok = 1'b0;
                endcase
            end
            OPTYPE_2R12I: begin
                case (issue.spec_op)
                    OP_SLTI, OP_SLTUI:          res_sel = SEL_CMP;
                    OP_ADDI:                    res_sel = SEL_ADDSUB;
                    OP_ANDI, OP_ORI, OP_XORI:   res_sel = SEL_LOGIC;
                    default:                    op_ok = 1'b0; // loads and stores go elsewhere
                endcase
            end
            OPTYPE_2R5I: begin
                res_sel = SEL_SHIFT;
                op_ok   = issue.spec_op inside {OP_SLLI, OP_SRLI, OP_SRAI};
            end
            OPTYPE_1R20I: begin
                res_sel = SEL_SHIFT; // upper immediates share the shift result
                op_ok   = issue.spec_op inside {OP_LU12I, OP_PCADDU12I};
            end
            OPTYPE_BJ: begin
                res_sel = SEL_BJ;
                op_ok   = issue.spec_op inside {OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU,
                                                OP_BGEU, OP_JIRL, OP_B, OP_BL};
            end
            default: begin
                op_ok = 1'b0;
            end
        endcase
    end

    // an invalid slot must never produce a result
    always_comb begin
        a_no_invalid_ok: assert final (!(op_ok && issue.gen_op == OPTYPE_INVALID));
    end

endmodule

//--- verilog/int_alu.sv
`timescale 1ns/1ns

module int_alu (
    input  logic                clk,
    input  logic                rst_n,
    input  fu_pkg::issue_info_t issue,
    input  fu_pkg::word_t       rj_val,
    input  fu_pkg::word_t       rk_val,
    input  logic                add_mode,
    output fu_pkg::word_t       addsub_res,
    output fu_pkg::word_t       shift_res,
    output fu_pkg::word_t       cmp_res,
    output fu_pkg::word_t       logic_res
);
    import fu_pkg::*;

    word_t       imm12_sx;
    word_t       imm12_zx;
    word_t       upper_imm;
    word_t       addend;
    logic  [4:0] shamt;
    word_t       shift_d;
    word_t       cmp_d;
    word_t       logic_d;

    assign imm12_sx  = {{20{issue.imm[11]}}, issue.imm[11:0]};
    assign imm12_zx  = {20'b0, issue.imm[11:0]}; // logic immediates are zero extended
    assign upper_imm = {issue.imm[19:0], 12'b0};
    assign addend    = (issue.gen_op == OPTYPE_3R) ? rk_val : imm12_sx;
    assign shamt     = (issue.gen_op == OPTYPE_2R5I) ? issue.imm[4:0] : rk_val[4:0];

    always_comb begin
        shift_d = '0;
        cmp_d   = '0;
        logic_d = '0;
        case (issue.gen_op)
            OPTYPE_3R: begin
                case (issue.spec_op)
                    OP_SLL:  shift_d = rj_val << shamt;
                    OP_SRL:  shift_d = rj_val >> shamt;
                    OP_SRA:  shift_d = $signed(rj_val) >>> shamt;
                    OP_SLT:  cmp_d = {31'b0, $signed(rj_val) < $signed(rk_val)};
                    OP_SLTU: cmp_d = {31'b0, rj_val < rk_val};
                    OP_NOR:  logic_d = ~(rj_val | rk_val);
                    OP_AND:  logic_d = rj_val & rk_val;
                    OP_OR:   logic_d = rj_val | rk_val;
                    OP_XOR:  logic_d = rj_val ^ rk_val;
                    default: ;
                endcase
            end
            OPTYPE_2R12I: begin
                case (issue.spec_op)
                    OP_SLTI:  cmp_d = {31'b0, $signed(rj_val) < $signed(imm12_sx)};
                    OP_SLTUI: cmp_d = {31'b0, rj_val < imm12_sx}; // sign-extended, unsigned compare
                    OP_ANDI:  logic_d = rj_val & imm12_zx;
                    OP_ORI:   logic_d = rj_val | imm12_zx;
                    OP_XORI:  logic_d = rj_val ^ imm12_zx;
                    default:  ;
                endcase
            end
            OPTYPE_2R5I: begin
                case (issue.spec_op)
                    OP_SLLI: shift_d = rj_val << shamt;
                    OP_SRLI: shift_d = rj_val >> shamt;
                    OP_SRAI: shift_d = $signed(rj_val) >>> shamt;
                    default: ;
                endcase
            end
            OPTYPE_1R20I: begin
                if (issue.spec_op == OP_LU12I) begin
                    shift_d = upper_imm;
                end else if (issue.spec_op == OP_PCADDU12I) begin
                    shift_d = issue.pc + upper_imm;
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addsub_res <= '0;
            shift_res  <= '0;
            cmp_res    <= '0;
            logic_res  <= '0;
        end else begin
            addsub_res <= add_mode ? rj_val + addend : rj_val - addend;
            shift_res  <= shift_d;
            cmp_res    <= cmp_d;
            logic_res  <= logic_d;
        end
    end

endmodule

//--- verilog/mul_unit.sv
`timescale 1ns/1ns

module mul_unit (
    input  logic          clk,
    input  logic          rst_n,
    input  fu_pkg::word_t rj_val,
    input  fu_pkg::word_t rk_val,
    input  logic          mul_signed_hi,
    output fu_pkg::word_t mul_lo,
    output fu_pkg::word_t mul_hi
);

    logic signed [32:0] a_ext;
    logic signed [32:0] b_ext;
    logic signed [65:0] prod;
    logic        [63:0] prod_q;

    // one extra bit lets a signed multiplier cover mulhu too
    assign a_ext = {mul_signed_hi & rj_val[31], rj_val};
    assign b_ext = {mul_signed_hi & rk_val[31], rk_val};
    assign prod  = a_ext * b_ext;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prod_q <= '0;
        end else begin
            prod_q <= prod[63:0]; // top two bits are only sign copies
        end
    end

    assign mul_lo = prod_q[31:0];
    assign mul_hi = prod_q[63:32];

endmodule

//--- verilog/branch_unit.sv
`timescale 1ns/1ns

module branch_unit (
    input  logic                clk,
    input  logic                rst_n,
    input  fu_pkg::issue_info_t issue,
    input  fu_pkg::word_t       rj_val,
    input  fu_pkg::word_t       rk_val,
    output fu_pkg::bj_out_t     bj
);
    import fu_pkg::*;

    word_t   off16;
    word_t   off26;
    bj_out_t bj_d;

    assign off16 = {{14{issue.imm[15]}}, issue.imm[15:0], 2'b00};
    assign off26 = {{4{issue.imm[25]}}, issue.imm[25:0], 2'b00};

    always_comb begin
        bj_d = '0;
        if (issue.gen_op == OPTYPE_BJ) begin
            bj_d.target = issue.pc + off16; // conditional branches
            case (issue.spec_op)
                OP_BEQ:  bj_d.taken = (rj_val == rk_val);
                OP_BNE:  bj_d.taken = (rj_val != rk_val);
                OP_BLT:  bj_d.taken = ($signed(rj_val) < $signed(rk_val));
                OP_BGE:  bj_d.taken = ($signed(rj_val) >= $signed(rk_val));
                OP_BLTU: bj_d.taken = (rj_val < rk_val);
                OP_BGEU: bj_d.taken = (rj_val >= rk_val);
                OP_JIRL: begin
                    bj_d.taken  = 1'b1;
                    bj_d.target = rj_val + off16; // register-relative
                end
                OP_B, OP_BL: begin
                    bj_d.taken  = 1'b1;
                    bj_d.target = issue.pc + off26;
                end
                default: bj_d.target = '0;
            endcase
            bj_d.pred_wrong = (bj_d.taken != issue.pred_taken) ||
                              (bj_d.taken && bj_d.target != issue.pred_target);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bj <= '0;
        end else begin
            bj <= bj_d;
        end
    end

    // a misprediction can only come from a branch issued the cycle before
    a_wrong_needs_bj: assert property (@(posedge clk) disable iff (!rst_n)
        bj.pred_wrong |-> $past(issue.gen_op) == OPTYPE_BJ);

endmodule

//--- verilog/wb_stage.sv
`timescale 1ns/1ns

module wb_stage #(
    parameter int PREG_IDX_W = 6,
    parameter int ROB_IDX_W  = 5
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  issue_valid,
    input  logic                  op_ok,
    input  fu_pkg::res_sel_t      res_sel,
    input  logic [PREG_IDX_W-1:0] rd_index,
    input  logic [ROB_IDX_W-1:0]  rob_index,
    input  fu_pkg::word_t         addsub_res,
    input  fu_pkg::word_t         shift_res,
    input  fu_pkg::word_t         cmp_res,
    input  fu_pkg::word_t         logic_res,
    input  fu_pkg::word_t         mul_lo,
    input  fu_pkg::word_t         mul_hi,
    input  fu_pkg::bj_out_t       bj,
    output fu_pkg::word_t         result,
    output logic [PREG_IDX_W-1:0] wb_rd_index,
    output logic [ROB_IDX_W-1:0]  wb_rob_index,
    output logic                  bj_taken,
    output logic                  pred_wrong,
    output logic                  result_valid
);
    import fu_pkg::*;

    res_sel_t sel_q; // aligned with the unit result registers

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result_valid <= 1'b0;
            sel_q        <= SEL_ADDSUB;
        end else begin
            result_valid <= issue_valid && op_ok;
            sel_q        <= res_sel;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd_index  <= rd_index;
        wb_rob_index <= rob_index;
    end

    always_comb begin
        case (sel_q)
            SEL_ADDSUB: result = addsub_res;
            SEL_SHIFT:  result = shift_res;
            SEL_CMP:    result = cmp_res;
            SEL_LOGIC:  result = logic_res;
            SEL_MUL_LO: result = mul_lo;
            SEL_MUL_HI: result = mul_hi;
            SEL_BJ:     result = bj.target; // branch target goes out on result
            default:    result = '0;
        endcase
    end

    assign bj_taken   = bj.taken;
    assign pred_wrong = bj.pred_wrong;

    // nothing may retire on the first edge out of reset
    a_quiet_after_reset: assert property (@(posedge clk) $rose(rst_n) |=> !result_valid);

endmodule

//--- verilog/simple_fu.sv
`timescale 1ns/1ns

module simple_fu #(
    parameter int PREG_IDX_W = 6,
    parameter int ROB_IDX_W  = 5
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  issue_valid,
    input  fu_pkg::issue_info_t   issue,
    input  fu_pkg::word_t         rj_val,
    input  fu_pkg::word_t         rk_val,
    input  logic [PREG_IDX_W-1:0] rd_index,
    input  logic [ROB_IDX_W-1:0]  rob_index,
    output fu_pkg::word_t         result,
    output logic [PREG_IDX_W-1:0] wb_rd_index,
    output logic [ROB_IDX_W-1:0]  wb_rob_index,
    output logic                  bj_taken,
    output logic                  pred_wrong,
    output logic                  result_valid
);
    import fu_pkg::*;

    res_sel_t res_sel;
    logic     add_mode;
    logic     mul_signed_hi;
    logic     op_ok;
    word_t    addsub_res;
    word_t    shift_res;
    word_t    cmp_res;
    word_t    logic_res;
    word_t    mul_lo;
    word_t    mul_hi;
    bj_out_t  bj;

    op_decode i_op_decode (
        .issue         (issue),
        .res_sel       (res_sel),
        .add_mode      (add_mode),
        .mul_signed_hi (mul_signed_hi),
        .op_ok         (op_ok)
    );

    int_alu i_int_alu (
        .clk        (clk),
        .rst_n      (rst_n),
        .issue      (issue),
        .rj_val     (rj_val),
        .rk_val     (rk_val),
        .add_mode   (add_mode),
        .addsub_res (addsub_res),
        .shift_res  (shift_res),
        .cmp_res    (cmp_res),
        .logic_res  (logic_res)
    );

    mul_unit i_mul_unit (
        .clk           (clk),
        .rst_n         (rst_n),
        .rj_val        (rj_val),
        .rk_val        (rk_val),
        .mul_signed_hi (mul_signed_hi),
        .mul_lo        (mul_lo),
        .mul_hi        (mul_hi)
    );

    branch_unit i_branch_unit (
        .clk    (clk),
        .rst_n  (rst_n),
        .issue  (issue),
        .rj_val (rj_val),
        .rk_val (rk_val),
        .bj     (bj)
    );

    wb_stage #(
        .PREG_IDX_W (PREG_IDX_W),
        .ROB_IDX_W  (ROB_IDX_W)
    ) i_wb_stage (
        .clk          (clk),
        .rst_n        (rst_n),
        .issue_valid  (issue_valid),
        .op_ok        (op_ok),
        .res_sel      (res_sel),
        .rd_index     (rd_index),
        .rob_index    (rob_index),
        .addsub_res   (addsub_res),
        .shift_res    (shift_res),
        .cmp_res      (cmp_res),
        .logic_res    (logic_res),
        .mul_lo       (mul_lo),
        .mul_hi       (mul_hi),
        .bj           (bj),
        .result       (result),
        .wb_rd_index  (wb_rd_index),
        .wb_rob_index (wb_rob_index),
        .bj_taken     (bj_taken),
        .pred_wrong   (pred_wrong),
        .result_valid (result_valid)
    );

endmodule

//--- testbench/fu_checker.sv
`timescale 1ns/1ns

module fu_checker #(
    parameter int PREG_IDX_W = 6,
    parameter int ROB_IDX_W  = 5
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  chk_en,      // expected record present
    input  int                    vec_id,
    input  logic                  exp_valid,
    input  fu_pkg::word_t         exp_result,
    input  logic                  exp_taken,
    input  logic                  exp_wrong,
    input  logic [PREG_IDX_W-1:0] exp_rd,
    input  logic [ROB_IDX_W-1:0]  exp_rob,
    input  fu_pkg::word_t         result,
    input  logic [PREG_IDX_W-1:0] wb_rd_index,
    input  logic [ROB_IDX_W-1:0]  wb_rob_index,
    input  logic                  bj_taken,
    input  logic                  pred_wrong,
    input  logic                  result_valid,
    output int                    num_checked,
    output int                    num_errors
);
    import fu_pkg::*;

    logic                  due_en = 1'b0;
    int                    due_id;
    logic                  due_valid;
    word_t                 due_result;
    logic                  due_taken;
    logic                  due_wrong;
    logic [PREG_IDX_W-1:0] due_rd;
    logic [ROB_IDX_W-1:0]  due_rob;
    int                    checked = 0;
    int                    errors  = 0;
    int                    bad_fields;

    assign num_checked = checked;
    assign num_errors  = errors;

    task automatic compare(input string name, input logic [31:0] act, input logic [31:0] exp);
        if (act !== exp) begin
            $display("FAILED at %0t: %s expected %0h, got %0h", $time, name, exp, act);
            bad_fields++;
        end
    endtask

    // the DUT result for this record shows up after the same edge
    always @(posedge clk) begin
        due_en     <= chk_en;
        due_id     <= vec_id;
        due_valid  <= exp_valid;
        due_result <= exp_result;
        due_taken  <= exp_taken;
        due_wrong  <= exp_wrong;
        due_rd     <= exp_rd;
        due_rob    <= exp_rob;
    end

    always @(negedge clk) begin
        if (!rst_n) begin
            if (result_valid !== 1'b0) begin
                $display("FAILED at %0t: result_valid expected 0, got %b in reset",
                         $time, result_valid);
                errors++;
            end
        end else if (due_en) begin
            bad_fields = 0;
            compare("result_valid", 32'(result_valid), 32'(due_valid));
            if (due_valid) begin   // other outputs only matter for a real result
                compare("result", result, due_result);
                compare("bj_taken", 32'(bj_taken), 32'(due_taken));
                compare("pred_wrong", 32'(pred_wrong), 32'(due_wrong));
                compare("wb_rd_index", 32'(wb_rd_index), 32'(due_rd));
                compare("wb_rob_index", 32'(wb_rob_index), 32'(due_rob));
            end
            checked++;
            if (bad_fields != 0) begin
                errors++;
                $display("vector %0d failed", due_id);
            end else begin
                $display("vector %0d ok", due_id);
            end
        end
    end

endmodule

//--- testbench/tb_simple_fu.sv
`timescale 1ns/1ns

module tb_simple_fu;
    import fu_pkg::*;

    localparam int PREG_IDX_W = 6;
    localparam int ROB_IDX_W  = 5;
    localparam int MAX_WAIT   = 20;   // cycles allowed for the last checks
    localparam int N_RANDOM   = 4;

    logic                  clk;
    logic                  rst_n;
    logic                  issue_valid;
    issue_info_t           issue;
    word_t                 rj_val;
    word_t                 rk_val;
    logic [PREG_IDX_W-1:0] rd_index;
    logic [ROB_IDX_W-1:0]  rob_index;
    word_t                 result;
    logic [PREG_IDX_W-1:0] wb_rd_index;
    logic [ROB_IDX_W-1:0]  wb_rob_index;
    logic                  bj_taken;
    logic                  pred_wrong;
    logic                  result_valid;

    // expected record, goes out together with the stimulus
    logic                  chk_en;
    int                    vec_id;
    logic                  exp_valid;
    word_t                 exp_result;
    logic                  exp_taken;
    logic                  exp_wrong;
    logic [PREG_IDX_W-1:0] exp_rd;
    logic [ROB_IDX_W-1:0]  exp_rob;
    int                    num_checked;
    int                    num_errors;

    // fields of the vector being prepared
    logic                  f_valid;
    gen_op_t               f_gen;
    spec_op_t              f_spec;
    imm_t                  f_imm;
    word_t                 f_pc;
    logic                  f_pt;
    word_t                 f_ptgt;
    word_t                 f_rj;
    word_t                 f_rk;
    logic [PREG_IDX_W-1:0] f_rd;
    logic [ROB_IDX_W-1:0]  f_rob;
    word_t                 f_res;
    logic                  f_taken;
    logic                  f_wrong;
    logic                  f_exp_valid;

    integer                seed;
    int                    fd;
    int                    sent;
    int                    tb_errors;
    int                    wait_cycles;
    logic                  timed_out;

    simple_fu #(
        .PREG_IDX_W (PREG_IDX_W),
        .ROB_IDX_W  (ROB_IDX_W)
    ) i_simple_fu (
        .clk          (clk),
        .rst_n        (rst_n),
        .issue_valid  (issue_valid),
        .issue        (issue),
        .rj_val       (rj_val),
        .rk_val       (rk_val),
        .rd_index     (rd_index),
        .rob_index    (rob_index),
        .result       (result),
        .wb_rd_index  (wb_rd_index),
        .wb_rob_index (wb_rob_index),
        .bj_taken     (bj_taken),
        .pred_wrong   (pred_wrong),
        .result_valid (result_valid)
    );

    fu_checker #(
        .PREG_IDX_W (PREG_IDX_W),
        .ROB_IDX_W  (ROB_IDX_W)
    ) i_fu_checker (
        .clk          (clk),
        .rst_n        (rst_n),
        .chk_en       (chk_en),
        .vec_id       (vec_id),
        .exp_valid    (exp_valid),
        .exp_result   (exp_result),
        .exp_taken    (exp_taken),
        .exp_wrong    (exp_wrong),
        .exp_rd       (exp_rd),
        .exp_rob      (exp_rob),
        .result       (result),
        .wb_rd_index  (wb_rd_index),
        .wb_rob_index (wb_rob_index),
        .bj_taken     (bj_taken),
        .pred_wrong   (pred_wrong),
        .result_valid (result_valid),
        .num_checked  (num_checked),
        .num_errors   (num_errors)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic set_idle();
        issue_valid = 1'b0;
        issue       = '0;
        rj_val      = '0;
        rk_val      = '0;
        rd_index    = '0;
        rob_index   = '0;
        chk_en      = 1'b0;
        vec_id      = 0;
        exp_valid   = 1'b0;
        exp_result  = '0;
        exp_taken   = 1'b0;
        exp_wrong   = 1'b0;
        exp_rd      = '0;
        exp_rob     = '0;
    endtask

    // one operation per cycle, shortly after the edge
    task automatic drive_vector();
        @(posedge clk);
        #2;
        issue_valid       = f_valid;
        issue.gen_op      = f_gen;
        issue.spec_op     = f_spec;
        issue.imm         = f_imm;
        issue.pc          = f_pc;
        issue.pred_taken  = f_pt;
        issue.pred_target = f_ptgt;
        rj_val            = f_rj;
        rk_val            = f_rk;
        rd_index          = f_rd;
        rob_index         = f_rob;
        chk_en            = 1'b1;
        vec_id            = sent;
        exp_valid         = f_exp_valid;
        exp_result        = f_res;
        exp_taken         = f_taken;
        exp_wrong         = f_wrong;
        exp_rd            = f_rd;
        exp_rob           = f_rob;
        sent++;
    endtask

    task automatic play_file();
        string line;
        int    n;
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n == 0 || line.len() < 2 || line[0] == "#") begin
                continue;   // blank or comment line
            end
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        f_valid, f_gen, f_spec, f_imm, f_pc, f_pt, f_ptgt, f_rj, f_rk,
                        f_rd, f_rob, f_res, f_taken, f_wrong, f_exp_valid);
            if (n != 15) begin
                $display("malformed line in the vector file: %s", line);
                tb_errors++;
            end else begin
                drive_vector();
            end
        end
    endtask

    // random 3R filler ops, expected value from the ISA rule
    task automatic play_random(input int count);
        for (int i = 0; i < count; i++) begin
            f_valid     = 1'b1;
            f_gen       = OPTYPE_3R;
            f_imm       = '0;
            f_pc        = '0;
            f_pt        = 1'b0;
            f_ptgt      = '0;
            f_rj        = $random(seed);
            f_rk        = $random(seed);
            f_rd        = PREG_IDX_W'(48 + i);
            f_rob       = ROB_IDX_W'(16 + i);
            f_taken     = 1'b0;
            f_wrong     = 1'b0;
            f_exp_valid = 1'b1;
            case (i % 4)
                0: begin
                    f_spec = OP_ADD;
                    f_res  = f_rj + f_rk;
                end
                1: begin
                    f_spec = OP_SUB;
                    f_res  = f_rj - f_rk;
                end
                2: begin
                    f_spec = OP_XOR;
                    f_res  = f_rj ^ f_rk;
                end
                default: begin
                    f_spec = OP_AND;
                    f_res  = f_rj & f_rk;
                end
            endcase
            drive_vector();
        end
    endtask

    initial begin
        seed      = 32'hf559_c285;
        sent      = 0;
        tb_errors = 0;
        rst_n     = 1'b0;
        set_idle();
        repeat (8) @(posedge clk);
        #2;
        rst_n = 1'b1;
        fd = $fopen("testbench/fu_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open testbench/fu_vectors.txt");
            tb_errors++;
        end else begin
            play_file();
            $fclose(fd);
            play_random(N_RANDOM);
        end
        @(posedge clk);
        #2;
        set_idle();
        wait_cycles = 0;
        while (num_checked < sent && wait_cycles < MAX_WAIT) begin
            @(posedge clk);
            wait_cycles++;
        end
        timed_out = (num_checked < sent);
        if (timed_out) begin
            $display("timeout: the checker saw only %0d of %0d vectors", num_checked, sent);
        end
        $display("tests run: %0d, failed: %0d", num_checked, num_errors + tb_errors);
        if (timed_out || num_errors != 0 || tb_errors != 0) begin
            $display("Some tests failed");
        end else begin
            $display("All tests passed");
        end
        $finish;
    end

endmodule

//--- testbench/fu_vectors.txt
# valid gen_op spec_op imm pc pred_taken pred_target rj rk rd rob, all hex
# then expected: result bj_taken pred_wrong result_valid
0 1 00 0000000 00000000 0 00000000 00000001 00000002 00 00 00000000 0 0 0
1 1 00 0000000 00000000 0 00000000 fffffff0 00000003 01 01 fffffff3 0 0 1
1 1 01 0000000 00000000 0 00000000 fffffff0 00000003 02 02 ffffffed 0 0 1
1 2 02 000fffc 00000000 0 00000000 00000010 12345678 03 03 0000000c 0 0 1
1 1 05 0000000 00000000 0 00000000 f0f0f0f0 ff00ff00 04 04 f000f000 0 0 1
1 1 06 0000000 00000000 0 00000000 f0f0f0f0 ff00ff00 05 05 fff0fff0 0 0 1
1 1 07 0000000 00000000 0 00000000 f0f0f0f0 ff00ff00 06 06 0ff00ff0 0 0 1
1 1 04 0000000 00000000 0 00000000 f0f0f0f0 ff00ff00 07 07 000f000f 0 0 1
1 2 03 00008ff 00000000 0 00000000 ffffffff 00000000 08 08 000008ff 0 0 1
1 2 04 0000800 00000000 0 00000000 12340000 00000000 09 09 12340800 0 0 1
1 2 05 0000fff 00000000 0 00000000 0000f0f0 00000000 0a 0a 0000ff0f 0 0 1
# shifts and upper immediates
1 1 08 0000000 00000000 0 00000000 00000003 00000024 0b 0b 00000030 0 0 1
1 1 09 0000000 00000000 0 00000000 80000000 00000004 0c 0c 08000000 0 0 1
1 1 0a 0000000 00000000 0 00000000 80000000 00000004 0d 0d f8000000 0 0 1
1 3 00 0000028 00000000 0 00000000 000000ff 00000001 0e 0e 0000ff00 0 0 1
1 3 01 0000004 00000000 0 00000000 f0000000 00000000 0f 0f 0f000000 0 0 1
1 3 02 0000004 00000000 0 00000000 f0000000 00000000 10 10 ff000000 0 0 1
1 4 00 0012345 00000000 0 00000000 00000000 00000000 11 11 12345000 0 0 1
1 4 01 00fffff 1c000100 0 00000000 00000000 00000000 12 12 1bfff100 0 0 1
# compares and multiplies
1 1 02 0000000 00000000 0 00000000 ffffffff 00000001 13 13 00000001 0 0 1
1 1 03 0000000 00000000 0 00000000 ffffffff 00000001 14 14 00000000 0 0 1
1 2 00 0000fff 00000000 0 00000000 00000005 00000000 15 15 00000000 0 0 1
1 2 01 0000fff 00000000 0 00000000 00000005 00000000 16 16 00000001 0 0 1
1 1 0b 0000000 00000000 0 00000000 fffffffe 00000003 17 17 fffffffa 0 0 1
1 1 0c 0000000 00000000 0 00000000 fffffffe 00000003 18 18 ffffffff 0 0 1
1 1 0d 0000000 00000000 0 00000000 fffffffe 00000003 19 19 00000002 0 0 1
# load code in the 2R12I class is not handled here
1 2 08 0000000 00000000 0 00000000 00000001 00000002 1a 1a 00000000 0 0 0
# branches, each kind with a right and a wrong prediction
1 5 00 0000010 1c000100 1 1c000140 00000005 00000005 1b 1b 1c000140 1 0 1
1 5 00 0000010 1c000100 0 00000000 00000005 00000005 1c 1c 1c000140 1 1 1
1 5 01 000fff0 1c000100 0 00000000 00000005 00000005 1d 1d 1c0000c0 0 0 1
1 5 01 000fff0 1c000100 1 1c0000c0 00000005 00000005 1e 1e 1c0000c0 0 1 1
1 5 02 0000010 1c000100 1 1c000140 ffffffff 00000001 1f 1f 1c000140 1 0 1
1 5 02 0000010 1c000100 1 1c000144 ffffffff 00000001 20 00 1c000140 1 1 1
1 5 03 0000020 1c000100 0 00000000 ffffffff 00000001 21 01 1c000180 0 0 1
1 5 03 0000020 1c000100 1 1c000180 ffffffff 00000001 22 02 1c000180 0 1 1
1 5 04 0000010 1c000100 0 00000000 ffffffff 00000001 23 03 1c000140 0 0 1
1 5 04 0000010 1c000100 1 1c000140 ffffffff 00000001 24 04 1c000140 0 1 1
1 5 05 0000010 1c000100 1 1c000140 ffffffff 00000001 25 05 1c000140 1 0 1
1 5 05 0000010 1c000100 0 00000000 ffffffff 00000001 26 06 1c000140 1 1 1
1 5 06 0000004 1c000100 1 1c002010 1c002000 00000000 27 07 1c002010 1 0 1
1 5 06 0000004 1c000100 1 1c000110 1c002000 00000000 28 08 1c002010 1 1 1
1 5 07 0000100 1c000100 1 1c000500 00000000 00000000 29 09 1c000500 1 0 1
1 5 07 0000100 1c000100 0 00000000 00000000 00000000 2a 0a 1c000500 1 1 1
1 5 08 3ffff00 1c000100 1 1bfffd00 00000000 00000000 2b 0b 1bfffd00 1 0 1
1 5 08 3ffff00 1c000100 1 1c000500 00000000 00000000 2c 0c 1bfffd00 1 1 1
0 1 00 0000000 00000000 0 00000000 00000001 00000002 2d 0d 00000000 0 0 0

//--- src.f
common/fu_pkg.sv
verilog/op_decode.sv
verilog/int_alu.sv
verilog/mul_unit.sv
verilog/branch_unit.sv
verilog/wb_stage.sv
verilog/simple_fu.sv
testbench/fu_checker.sv
testbench/tb_simple_fu.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing -Wno-fatal --top-module tb_simple_fu -f src.f -o fu_sim \
    > build.log 2>&1 || { echo "verilator build failed, see build.log"; exit 1; }
./obj_dir/fu_sim > sim.log 2>&1
cat sim.log
grep -q "Some tests failed" sim.log && { echo "simulation reported errors"; exit 1; }
grep -q "All tests passed" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"
